/* aes_device.f */
+incdir+hw
hw/aes_ctrl_pkg.sv
hw/aes_data_pkg.sv
hw/key_store_if.sv
hw/aes_key_expander.sv
hw/aes_key_store.sv
hw/aes_round_engine.sv
hw/aes_device_ctrl.sv
hw/aes_device.sv
tb/tb_clock_gen.sv
tb/aes_device_checker.sv
tb/aes_device_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the AES device testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module aes_device_tb -f aes_device.f -o aes_device_sim

out=$(./obj_dir/aes_device_sim) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

/* tb/aes_device_tb.sv */
// ==========================================================================
// testbench for the AES-256 device
// reset state, refused commands, keygen, random encrypt and decrypt
// against a reference model, rekeying, watchdog and summary
// ==========================================================================

`timescale 1ns/1ps
`include "aes_device_params.svh"

module aes_device_tb;
    import aes_ctrl_pkg::*;
    import aes_data_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int LATENCY    = 15;
    localparam int DONE_LIMIT = 40;
    localparam int NUM_ENC    = 20;
    localparam int NUM_RDEC   = 5;
    localparam int NUM_POST   = 4;
    localparam int NUM_TESTS  = 4 + 2 * NUM_ENC + NUM_RDEC + 2 * NUM_POST;

    logic   clk;
    logic   resetn;
    logic   cmd_valid;
    mode_e  cmd_mode;
    block_t data_in;
    seed_t  seed;
    logic   cmd_ready;
    block_t data_out;
    logic   enc_done;
    logic   dec_done;
    logic   kg_done;
    logic   keys_ready;

    integer     rng_seed = 35577;
    round_key_t model_keys [`AES_NUM_KEYS];
    block_t     plain_q [NUM_ENC];
    block_t     cipher_q [NUM_ENC];
    string      cur_test;
    bit         test_bad;
    int         tests_run;
    int         tests_bad;
    int         checks;
    int         errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) i_clock_gen (.clk(clk));

    aes_device i_aes_device (
        .clk        (clk),
        .resetn     (resetn),
        .cmd_valid  (cmd_valid),
        .cmd_mode   (cmd_mode),
        .data_in    (data_in),
        .seed       (seed),
        .cmd_ready  (cmd_ready),
        .data_out   (data_out),
        .enc_done   (enc_done),
        .dec_done   (dec_done),
        .kg_done    (kg_done),
        .keys_ready (keys_ready)
    );

    bind aes_device_ctrl aes_device_checker i_checker (
        .clk        (clk),
        .resetn     (resetn),
        .cmd_valid  (cmd_valid),
        .cmd_mode   (cmd_mode),
        .cmd_ready  (cmd_ready),
        .kg_done    (kg_done),
        .enc_done   (enc_done),
        .dec_done   (dec_done),
        .keys_ready (keys_ready)
    );

    // reference model, byte rotations as shifts
    function automatic block_t rot_left_byte(input block_t x);
        return (x << 8) | (x >> (`AES_BLOCK_W - 8));
    endfunction

    function automatic block_t rot_right_byte(input block_t x);
        return (x >> 8) | (x << (`AES_BLOCK_W - 8));
    endfunction

    // seed halves, then key i-2 ^ rotl(key i-1) ^ i
    task automatic load_model_keys(input seed_t s);
        model_keys[0] = s[`AES_SEED_W-1:`AES_BLOCK_W];
        model_keys[1] = s[`AES_BLOCK_W-1:0];
        for (int i = 2; i < `AES_NUM_KEYS; i++)
            model_keys[i] = model_keys[i-2] ^ rot_left_byte(model_keys[i-1]) ^ round_key_t'(i);
    endtask

    function automatic block_t model_encrypt(input block_t pt);
        block_t s;
        s = pt ^ model_keys[0];
        for (int r = 1; r <= `AES_ROUNDS; r++)
            s = rot_left_byte(s) ^ model_keys[r];
        return s;
    endfunction

    function automatic block_t model_decrypt(input block_t ct);
        block_t s;
        s = ct;
        for (int r = `AES_ROUNDS; r >= 1; r--)
            s = rot_right_byte(s ^ model_keys[r]);
        return s ^ model_keys[0];
    endfunction

    // random stimulus, 32 bits per call
    function automatic block_t random_block();
        block_t b;
        for (int w = 0; w < 4; w++)
            b[32*w +: 32] = $random(rng_seed);
        return b;
    endfunction

    function automatic seed_t random_seed();
        seed_t s;
        s[`AES_SEED_W-1:`AES_BLOCK_W] = random_block();
        s[`AES_BLOCK_W-1:0] = random_block();
        return s;
    endfunction

    task automatic begin_test(input string name);
        cur_test = name;
        test_bad = 1'b0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_bad)
        begin
            tests_bad++;
            $display("test %s: failed", cur_test);
        end
        else
            $display("test %s: ok", cur_test);
    endtask

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("[FAIL] %s %s expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("%s: %s", cur_test, what);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    function automatic logic done_pulse(input mode_e m);
        case (m)
            MODE_KEYGEN:  return kg_done;
            MODE_DECRYPT: return dec_done;
            default:      return enc_done;
        endcase
    endfunction

    // hold the command until accepted, then wait for its done pulse
    // edges is rising edges from acceptance to the pulse, -1 if none
    task automatic run_command(input mode_e mode, input block_t data, input seed_t key_seed,
                               output int edges);
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd_mode  = mode;
        data_in   = data;
        seed      = key_seed;
        // ready is settled mid-cycle
        @(negedge clk);
        while (!cmd_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        edges = -1;
        for (int n = 1; n <= DONE_LIMIT && edges < 0; n++)
        begin
            @(negedge clk);
            if (done_pulse(mode))
                edges = n - 1;
            else if (mode == MODE_KEYGEN)
                check_true(!keys_ready, "keys_ready high while keys are being generated");
        end
        check_true(edges >= 0, "no done pulse after the command");
    endtask

    task automatic keygen_test(input string name, input seed_t key_seed);
        int edges;
        begin_test(name);
        run_command(MODE_KEYGEN, '0, key_seed, edges);
        check_value("latency", 128'(LATENCY), 128'(edges));
        check_true(keys_ready, "keys_ready still low at kg_done");
        load_model_keys(key_seed);
        end_test();
    endtask

    task automatic crypt_test(input string name, input mode_e mode, input block_t data,
                              input block_t expected);
        int edges;
        begin_test(name);
        run_command(mode, data, '0, edges);
        check_value("latency", 128'(LATENCY), 128'(edges));
        check_value("data_out", expected, data_out);
        end_test();
    endtask

    initial
    begin
        block_t blk;
        // idle ready depends on the presented mode, keygen is always allowed
        cmd_valid = 1'b0;
        cmd_mode  = MODE_KEYGEN;
        data_in   = '0;
        seed      = '0;
        resetn    = 1'b0;
        tests_run = 0;
        tests_bad = 0;
        checks    = 0;
        errors    = 0;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        begin_test("reset_state");
        @(negedge clk);
        check_true(cmd_ready, "cmd_ready low after reset");
        check_true(!keys_ready, "keys_ready high after reset");
        check_value("data_out", '0, data_out);
        check_true(!(kg_done || enc_done || dec_done), "done flag high after reset");
        end_test();

        // encrypt, decrypt and code 3 refused before any keygen
        begin_test("crypt_blocked");
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        for (int m = 0; m < 4; m++)
        begin
            if (m != 2)
            begin
                cmd_mode = mode_e'(m[1:0]);
                @(negedge clk);
                check_true(!cmd_ready, "cmd_ready high for a command that must be refused");
                check_true(!(enc_done || dec_done), "crypt done flag without a command");
                @(posedge clk);
                #1;
            end
        end
        cmd_valid = 1'b0;
        cmd_mode  = MODE_KEYGEN;
        end_test();

        keygen_test("keygen_1", random_seed());

        for (int i = 0; i < NUM_ENC; i++)
        begin
            plain_q[i]  = random_block();
            cipher_q[i] = model_encrypt(plain_q[i]);
            crypt_test($sformatf("enc_%02d", i), MODE_ENCRYPT, plain_q[i], cipher_q[i]);
        end

        // round trip back to the original blocks
        for (int i = 0; i < NUM_ENC; i++)
            crypt_test($sformatf("dec_%02d", i), MODE_DECRYPT, cipher_q[i], plain_q[i]);

        for (int i = 0; i < NUM_RDEC; i++)
        begin
            blk = random_block();
            crypt_test($sformatf("rdec_%0d", i), MODE_DECRYPT, blk, model_decrypt(blk));
        end

        // new seed, results must follow the new schedule
        keygen_test("keygen_2", random_seed());
        for (int i = 0; i < NUM_POST; i++)
        begin
            blk = random_block();
            crypt_test($sformatf("rekey_enc_%0d", i), MODE_ENCRYPT, blk, model_encrypt(blk));
            crypt_test($sformatf("rekey_dec_%0d", i), MODE_DECRYPT, model_encrypt(blk), blk);
        end

        $display("tests %0d, failed tests %0d, checks %0d, check errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // upper bound on run time, 40 cycles per test
    initial
    begin
        #(NUM_TESTS * DONE_LIMIT * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", NUM_TESTS * DONE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb/aes_device_checker.sv */
// ==========================================================================
// protocol assertions for the device controller
// done pulse width, ready held low while a command runs,
// keys-ready only falls on an accepted keygen
// ==========================================================================

`timescale 1ns/1ps

module aes_device_checker (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 cmd_valid,
    input  aes_ctrl_pkg::mode_e  cmd_mode,
    input  logic                 cmd_ready,
    input  logic                 kg_done,
    input  logic                 enc_done,
    input  logic                 dec_done,
    input  logic                 keys_ready
);
    import aes_ctrl_pkg::*;

    logic busy_q;
    logic any_done;

    assign any_done = kg_done || enc_done || dec_done;

    // command in flight, set on acceptance, cleared after its done pulse
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            busy_q <= 1'b0;
        else if (cmd_valid && cmd_ready)
            busy_q <= 1'b1;
        else if (any_done)
            busy_q <= 1'b0;
    end

    // single-cycle done pulses
    assert property (@(posedge clk) disable iff (!resetn) kg_done |=> !kg_done)
        else $error("kg_done high for more than one cycle");
    assert property (@(posedge clk) disable iff (!resetn) enc_done |=> !enc_done)
        else $error("enc_done high for more than one cycle");
    assert property (@(posedge clk) disable iff (!resetn) dec_done |=> !dec_done)
        else $error("dec_done high for more than one cycle");

    // no second command while one runs
    assert property (@(posedge clk) disable iff (!resetn) (busy_q && !any_done) |-> !cmd_ready)
        else $error("cmd_ready high while a command is still running");

    // stored keys are only invalidated by a new keygen
    assert property (@(posedge clk) disable iff (!resetn)
        $fell(keys_ready) |-> $past(cmd_valid && cmd_ready && (cmd_mode == MODE_KEYGEN)))
        else $error("keys_ready fell without an accepted keygen command");

endmodule

/* tb/tb_clock_gen.sv */
// ==========================================================================
// free-running testbench clock, 100 ns period by default
// ==========================================================================

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // starts low, first rising edge at half a period
    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* hw/aes_device.sv */
// ==========================================================================
// AES-256 device top level
// controller, key expander, key store and round engine
// ==========================================================================

`timescale 1ns/1ps

module aes_device (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  cmd_valid,
    input  aes_ctrl_pkg::mode_e   cmd_mode,
    input  aes_data_pkg::block_t  data_in,
    input  aes_data_pkg::seed_t   seed,
    output logic                  cmd_ready,
    output aes_data_pkg::block_t  data_out,
    output logic                  enc_done,
    output logic                  dec_done,
    output logic                  kg_done,
    output logic                  keys_ready
);

    logic                 exp_start;
    logic                 exp_done;
    logic                 eng_start;
    logic                 eng_decrypt;
    logic                 eng_done;
    aes_data_pkg::block_t eng_block;

    // expander writes, engine reads
    key_store_if ks_bus ();

    aes_device_ctrl i_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd_mode    (cmd_mode),
        .exp_done    (exp_done),
        .eng_done    (eng_done),
        .eng_block   (eng_block),
        .cmd_ready   (cmd_ready),
        .exp_start   (exp_start),
        .eng_start   (eng_start),
        .eng_decrypt (eng_decrypt),
        .data_out    (data_out),
        .enc_done    (enc_done),
        .dec_done    (dec_done),
        .kg_done     (kg_done),
        .keys_ready  (keys_ready)
    );

    aes_key_expander i_key_expander (
        .clk    (clk),
        .resetn (resetn),
        .start  (exp_start),
        .seed   (seed),
        .done   (exp_done),
        .ks     (ks_bus.writer)
    );

    aes_key_store i_key_store (
        .clk    (clk),
        .resetn (resetn),
        .ks     (ks_bus.store)
    );

    aes_round_engine i_round_engine (
        .clk       (clk),
        .resetn    (resetn),
        .start     (eng_start),
        .decrypt   (eng_decrypt),
        .block_in  (data_in),
        .done      (eng_done),
        .block_out (eng_block),
        .ks        (ks_bus.reader)
    );

endmodule

/* hw/aes_device_ctrl.sv */
// ==========================================================================
// device controller
// command acceptance, mode sequencing, keys-ready flag, result register
// and the per-mode done pulses
// ==========================================================================

`timescale 1ns/1ps

module aes_device_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  cmd_valid,
    input  aes_ctrl_pkg::mode_e   cmd_mode,
    input  logic                  exp_done,
    input  logic                  eng_done,
    input  aes_data_pkg::block_t  eng_block,
    output logic                  cmd_ready,
    output logic                  exp_start,
    output logic                  eng_start,
    output logic                  eng_decrypt,
    output aes_data_pkg::block_t  data_out,
    output logic                  enc_done,
    output logic                  dec_done,
    output logic                  kg_done,
    output logic                  keys_ready
);
    import aes_ctrl_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        mode_ok;
    logic        accept;
    logic        dir_q;
    logic        finish_kg;
    logic        finish_crypt;

    // keygen always allowed, crypt only once keys are stored
    always_comb
    begin
        case (cmd_mode)
            MODE_KEYGEN:                mode_ok = 1'b1;
            MODE_ENCRYPT, MODE_DECRYPT: mode_ok = keys_ready;
            default:                    mode_ok = 1'b0;
        endcase
    end

    assign cmd_ready = (state_q == ST_IDLE) && mode_ok;
    assign accept    = cmd_valid && cmd_ready;

    // start pulses sit on the accepting cycle so seed and data are taken there
    assign exp_start   = accept && (cmd_mode == MODE_KEYGEN);
    assign eng_start   = accept && (cmd_mode != MODE_KEYGEN);
    assign eng_decrypt = (cmd_mode == MODE_DECRYPT);

    // sub-block done flags only count in the matching state
    assign finish_kg    = (state_q == ST_KEYGEN) && exp_done;
    assign finish_crypt = (state_q == ST_CRYPT) && eng_done;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (exp_start)
                    state_d = ST_KEYGEN;
                else if (eng_start)
                    state_d = ST_CRYPT;
            end
            ST_KEYGEN:
            begin
                if (finish_kg)
                    state_d = ST_IDLE;
            end
            ST_CRYPT:
            begin
                if (finish_crypt)
                    state_d = ST_IDLE;
            end
            default:
                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q    <= ST_IDLE;
            dir_q      <= 1'b0;
            keys_ready <= 1'b0;
            kg_done    <= 1'b0;
            enc_done   <= 1'b0;
            dec_done   <= 1'b0;
            data_out   <= '0;
        end
        else
        begin
            state_q  <= state_d;
            // one-cycle pulses
            kg_done  <= finish_kg;
            enc_done <= finish_crypt && !dir_q;
            dec_done <= finish_crypt && dir_q;
            // direction of the running command
            if (eng_start)
                dir_q <= eng_decrypt;
            // new keygen invalidates the stored keys
            if (exp_start)
                keys_ready <= 1'b0;
            else if (finish_kg)
                keys_ready <= 1'b1;
            // result held until the next crypt finishes
            if (finish_crypt)
                data_out <= eng_block;
        end
    end

endmodule

/* hw/aes_round_engine.sv */
// ==========================================================================
// iterative round engine, both directions
// encrypt: xor key 0, then rotl8 and xor key r for r = 1..14
// decrypt: xor key r and rotr8 for r = 14..1, then xor key 0
// ==========================================================================

`timescale 1ns/1ps
`include "aes_device_params.svh"

module aes_round_engine (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  logic                  decrypt,
    input  aes_data_pkg::block_t  block_in,
    output logic                  done,
    output aes_data_pkg::block_t  block_out,
    key_store_if.reader           ks
);
    import aes_data_pkg::*;

    localparam key_addr_t LAST_ROUND = key_addr_t'(`AES_ROUNDS);

    logic      busy_q;
    logic      decrypt_q;
    key_addr_t addr_q;
    key_addr_t last_addr;
    block_t    state_q;
    block_t    mixed;
    block_t    round_out;

    // round counter is the key address
    assign ks.rd_addr = addr_q;

    // encrypt counts up to 14, decrypt down to 0
    assign last_addr = decrypt_q ? '0 : LAST_ROUND;

    // one step per busy cycle
    // key 0 step has no rotate in either direction
    always_comb
    begin
        mixed = state_q ^ ks.rd_key;
        if (addr_q == '0)
            round_out = mixed;
        else if (decrypt_q)
            round_out = rotr8(mixed);
        else
            round_out = rotl8(state_q) ^ ks.rd_key;
    end

    // final step in progress, result is the step output
    assign done      = busy_q && (addr_q == last_addr);
    assign block_out = round_out;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy_q    <= 1'b0;
            decrypt_q <= 1'b0;
            addr_q    <= '0;
        end
        else if (start)
        begin
            busy_q    <= 1'b1;
            decrypt_q <= decrypt;
            addr_q    <= decrypt ? LAST_ROUND : '0;
        end
        else if (busy_q)
        begin
            if (done)
                busy_q <= 1'b0;
            else if (decrypt_q)
                addr_q <= addr_q - key_addr_t'(1);
            else
                addr_q <= addr_q + key_addr_t'(1);
        end
    end

    // block state
    always_ff @(posedge clk)
    begin
        if (start)
            state_q <= block_in;
        else if (busy_q)
            state_q <= round_out;
    end

endmodule

/* hw/aes_key_store.sv */
// ==========================================================================
// round-key store
// 15-entry register array, clocked write, combinational read
// ==========================================================================

`timescale 1ns/1ps
`include "aes_device_params.svh"

module aes_key_store (
    input  logic       clk,
    input  logic       resetn,
    key_store_if.store ks
);
    import aes_data_pkg::*;

    localparam int NUM_KEYS = `AES_NUM_KEYS;

    round_key_t keys_q [NUM_KEYS];

    // array reads zero until the first key generation
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < NUM_KEYS; i++)
                keys_q[i] <= '0;
        end
        else if (ks.wr_en && (ks.wr_addr < key_addr_t'(NUM_KEYS)))
        begin
            keys_q[ks.wr_addr] <= ks.wr_key;
        end
    end

    // address 15 has no entry, reads as zero
    assign ks.rd_key = (ks.rd_addr < key_addr_t'(NUM_KEYS)) ? keys_q[ks.rd_addr] : '0;

endmodule

/* hw/aes_key_expander.sv */
// ==========================================================================
// round-key generator
// writes one key per cycle into the key store, keys 0 and 1 from the seed,
// the rest from the two previous keys
// ==========================================================================

`timescale 1ns/1ps
`include "aes_device_params.svh"

module aes_key_expander (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  aes_data_pkg::seed_t  seed,
    output logic                 done,
    key_store_if.writer          ks
);
    import aes_data_pkg::*;

    localparam key_addr_t LAST_KEY = key_addr_t'(`AES_NUM_KEYS - 1);

    logic       busy_q;
    key_addr_t  cnt_q;
    seed_t      seed_q;
    round_key_t key_m2_q;
    round_key_t key_m1_q;
    round_key_t next_key;

    // key i = key i-2 ^ rotl8(key i-1) ^ i in the low byte
    always_comb
    begin
        if (cnt_q == '0)
            next_key = seed_q[`AES_SEED_W-1 -: `AES_BLOCK_W];
        else if (cnt_q == key_addr_t'(1))
            next_key = seed_q[`AES_BLOCK_W-1:0];
        else
            next_key = key_m2_q ^ rotl8(key_m1_q) ^ round_key_t'(cnt_q);
    end

    // write every busy cycle, count doubles as store address
    assign ks.wr_en   = busy_q;
    assign ks.wr_addr = cnt_q;
    assign ks.wr_key  = next_key;

    // flags the cycle of the last write
    assign done = busy_q && (cnt_q == LAST_KEY);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end
        else if (start)
        begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end
        else if (busy_q)
        begin
            if (done)
                busy_q <= 1'b0;
            else
                cnt_q <= cnt_q + key_addr_t'(1);
        end
    end

    // seed and the two most recent keys
    always_ff @(posedge clk)
    begin
        if (start)
            seed_q <= seed;
        if (busy_q)
        begin
            key_m2_q <= key_m1_q;
            key_m1_q <= next_key;
        end
    end

endmodule

/* hw/key_store_if.sv */
// ==========================================================================
// round-key store bus
// write port from the key expander, read port for the round engine
// ==========================================================================

`timescale 1ns/1ps

interface key_store_if;
    import aes_data_pkg::*;

    // write side, takes effect on the clock edge with wr_en high
    logic       wr_en;
    key_addr_t  wr_addr;
    round_key_t wr_key;

    // read side, combinational
    key_addr_t  rd_addr;
    round_key_t rd_key;

    // expander
    modport writer (output wr_en, wr_addr, wr_key);
    // round engine
    modport reader (output rd_addr, input rd_key);
    // register array, mirror of both
    modport store (input wr_en, wr_addr, wr_key, rd_addr, output rd_key);

endinterface

/* hw/aes_data_pkg.sv */
// ==========================================================================
// data types of the AES-256 device
// block, seed, round key, key address and byte rotate helpers
// ==========================================================================

`include "aes_device_params.svh"

package aes_data_pkg;

    typedef logic [`AES_BLOCK_W-1:0]    block_t;
    typedef logic [`AES_SEED_W-1:0]     seed_t;
    typedef logic [`AES_BLOCK_W-1:0]    round_key_t;
    typedef logic [`AES_KEY_ADDR_W-1:0] key_addr_t;

    // rotate left by one byte, top byte wraps to the bottom
    function automatic block_t rotl8(input block_t x);
        return {x[`AES_BLOCK_W-9:0], x[`AES_BLOCK_W-1 -: 8]};
    endfunction

    // inverse of rotl8
    function automatic block_t rotr8(input block_t x);
        return {x[7:0], x[`AES_BLOCK_W-1:8]};
    endfunction

endpackage

/* hw/aes_ctrl_pkg.sv */
// ==========================================================================
// control types of the AES-256 device
// command mode codes and controller state
// ==========================================================================

package aes_ctrl_pkg;

    // 2-bit command code
    // code 3 is left free and is refused by the controller
    typedef enum logic [1:0]
    {
        MODE_ENCRYPT = 2'b00,
        MODE_DECRYPT = 2'b01,
        MODE_KEYGEN  = 2'b10
    } mode_e;

    // controller states
    // idle takes commands, the other two wait for a done flag
    typedef enum logic [1:0]
    {
        ST_IDLE   = 2'b00,
        ST_KEYGEN = 2'b01,
        ST_CRYPT  = 2'b10
    } ctrl_state_e;

endpackage

/* hw/aes_device_params.svh */
// ==========================================================================
// shared constants for the AES-256 device
// block and seed widths, round count, round-key count and key address width
// ==========================================================================

`ifndef AES_DEVICE_PARAMS_SVH
`define AES_DEVICE_PARAMS_SVH

// one data block, also one round key
`define AES_BLOCK_W     128

// full AES-256 key material
`define AES_SEED_W      256

// rounds per block, plus one whitening key
`define AES_ROUNDS      14
`define AES_NUM_KEYS    15
`define AES_KEY_ADDR_W  4

`endif
